// File: Bender.yml
package:
  name: clock_display_addr

sources:
  - hw/clock_display_pkg.sv
  - hw/digit_store.sv
  - hw/screen_field_decode.sv
  - hw/glyph_address.sv
  - hw/clock_display_addr.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/clock_display_sva.sv
      - bench/tb_clock_display.sv

// File: bench/clock_display_sva.sv
`default_nettype none

module clock_display_sva (
    input logic                                               reloj,
    input logic                                               resetM,
    input logic [clock_display_pkg::PAIR_W-1:0]               dir_dato,
    input logic [clock_display_pkg::SLOT_W-1:0]               posicion,
    input logic                                               rd,
    input logic [clock_display_pkg::COL_W-1:0]                qh,
    input logic [clock_display_pkg::ROW_W+clock_display_pkg::LINE_W-1:0] qv,
    input logic [clock_display_pkg::ADDR_W-1:0]               dir_mem
);

    timeunit 1ns;
    timeprecision 1ps;

    import clock_display_pkg::*;

    typedef enum logic [1:0] {
        EXP_BLANK,
        EXP_DIGIT,
        EXP_NON_DECIMAL,
        EXP_CENTURY
    } exp_kind_e;

    typedef struct packed {
        exp_kind_e         kind;
        logic [ADDR_W-1:0] addr;
    } prediction_t;

    logic [PAIR_W-1:0] shadow [1:SLOT_COUNT];
    logic [COL_W-1:0]  col_s;
    logic [ROW_W-1:0]  row_s;
    logic [LINE_W-1:0] line_s;
    prediction_t       exp_q;

    int fail_count = 0;
    int checked_cycles = 0;

    function automatic logic [COL_W-1:0] field_start(input int slot);
        case (slot)
            1: return COL_TIME_HOUR;
            2: return COL_TIME_MIN;
            3: return COL_TIME_SEC;
            4: return COL_CRONO_HOUR;
            5: return COL_CRONO_MIN;
            6: return COL_CRONO_SEC;
            7: return COL_DAY;
            8: return COL_MONTH;
            default: return COL_YEAR;
        endcase
    endfunction

    // Slot whose field covers the cell, 0 when no digit field does
    function automatic int slot_at(input logic [COL_W-1:0] col, input logic [ROW_W-1:0] row);
        for (int s = 1; s <= SLOT_COUNT; s++) begin
            if (row == ((s <= 6) ? ROW_TIME : ROW_DATE) && int'(col) >= int'(field_start(s))
                    && int'(col) < int'(field_start(s)) + 4) begin
                return s;
            end
        end
        return 0;
    endfunction

    function automatic prediction_t predict(input logic [COL_W-1:0]  col,
                                            input logic [ROW_W-1:0]  row,
                                            input logic [LINE_W-1:0] line);
        int               slot;
        int               offset;
        logic [BCD_W-1:0] nib;
        prediction_t      p;
        p.kind = EXP_BLANK;
        p.addr = '0;
        slot = slot_at(col, row);
        if (slot != 0) begin
            offset = int'(col) - int'(field_start(slot));
            nib = (offset < 2) ? shadow[slot][PAIR_W-1 -: BCD_W] : shadow[slot][BCD_W-1:0];
            if (nib < BCD_W'(10)) begin
                p.kind = EXP_DIGIT;
                p.addr = {ASCII_ZERO + CHAR_W'(nib), line};
            end else begin
                p.kind = EXP_NON_DECIMAL;
                p.addr = {CHAR_W'(0), line};   // Code 0 but the glyph line stays
            end
        end else if (row == ROW_DATE && int'(col) >= int'(COL_CENTURY)
                && int'(col) < int'(COL_CENTURY) + 4) begin
            p.kind = EXP_CENTURY;
            if (int'(col) < int'(COL_CENTURY) + 2) begin
                p.addr = {CENTURY_HI, line};
            end else begin
                p.addr = {CENTURY_LO, line};
            end
        end
        return p;
    endfunction

    // Shadow slots follow the write rule, the prediction uses them before this edge
    always_ff @(posedge reloj) begin
        if (resetM) begin
            for (int i = 1; i <= SLOT_COUNT; i++) begin
                shadow[i] <= '0;
            end
            col_s  <= '0;
            row_s  <= '0;
            line_s <= '0;
            exp_q  <= '{kind: EXP_BLANK, addr: '0};
        end else begin
            if (!rd && posicion != '0 && int'(posicion) <= SLOT_COUNT) begin
                shadow[posicion] <= dir_dato;
            end
            col_s  <= qh;
            row_s  <= qv[ROW_W+LINE_W-1 -: ROW_W];
            line_s <= qv[LINE_W-1:0];
            exp_q  <= predict(col_s, row_s, line_s);
        end
    end

    always @(posedge reloj) begin
        if (!resetM) begin
            checked_cycles <= checked_cycles + 1;
        end
    end

    a_after_reset: assert property (@(posedge reloj) resetM |=> dir_mem == '0)
        else begin
            fail_count = fail_count + 1;
            $error("CHECK FAILED after_reset expected %h actual %h",
                   ADDR_W'(0), $sampled(dir_mem));
        end

    a_digit_field: assert property (@(posedge reloj) disable iff (resetM)
            exp_q.kind == EXP_DIGIT |-> dir_mem == exp_q.addr)
        else begin
            fail_count = fail_count + 1;
            $error("CHECK FAILED digit_field expected %h actual %h",
                   $sampled(exp_q.addr), $sampled(dir_mem));
        end

    a_century: assert property (@(posedge reloj) disable iff (resetM)
            exp_q.kind == EXP_CENTURY |-> dir_mem == exp_q.addr)
        else begin
            fail_count = fail_count + 1;
            $error("CHECK FAILED century expected %h actual %h",
                   $sampled(exp_q.addr), $sampled(dir_mem));
        end

    a_blank_cell: assert property (@(posedge reloj) disable iff (resetM)
            exp_q.kind == EXP_BLANK |-> dir_mem == '0)
        else begin
            fail_count = fail_count + 1;
            $error("CHECK FAILED blank_cell expected %h actual %h",
                   ADDR_W'(0), $sampled(dir_mem));
        end

    a_non_decimal: assert property (@(posedge reloj) disable iff (resetM)
            exp_q.kind == EXP_NON_DECIMAL |-> dir_mem == exp_q.addr)
        else begin
            fail_count = fail_count + 1;
            $error("CHECK FAILED non_decimal expected %h actual %h",
                   $sampled(exp_q.addr), $sampled(dir_mem));
        end

endmodule

bind clock_display_addr clock_display_sva sva_i (
    .reloj    (reloj),
    .resetM   (resetM),
    .dir_dato (dir_dato),
    .posicion (posicion),
    .rd       (rd),
    .qh       (qh),
    .qv       (qv),
    .dir_mem  (dir_mem)
);

`default_nettype wire

// File: bench/tb_clock_display.sv
`default_nettype none

module tb_clock_display;

    timeunit 1ns;
    timeprecision 1ps;

    import clock_display_pkg::*;

    localparam int SCAN_COLS      = 1 << COL_W;
    localparam int TIMEOUT_CYCLES = 4000;     // About twice what all scans take

    logic                    reloj;
    logic                    resetM;
    logic [PAIR_W-1:0]       dir_dato;
    logic [SLOT_W-1:0]       posicion;
    logic                    rd;
    logic [COL_W-1:0]        qh;
    logic [ROW_W+LINE_W-1:0] qv;
    logic [ADDR_W-1:0]       dir_mem;

    int cycle_count = 0;
    int errors;

    tb_clock_gen clock_gen_i (
        .reloj  (reloj),
        .resetM (resetM)
    );

    clock_display_addr dut_i (
        .reloj    (reloj),
        .resetM   (resetM),
        .dir_dato (dir_dato),
        .posicion (posicion),
        .rd       (rd),
        .qh       (qh),
        .qv       (qv),
        .dir_mem  (dir_mem)
    );

    // The strobe is active low, so 1 here means the write is ignored
    task automatic write_slot(input logic [SLOT_W-1:0] slot, input logic [PAIR_W-1:0] pair,
                              input logic strobe);
        @(posedge reloj);
        posicion <= slot;
        dir_dato <= pair;
        rd       <= strobe;
    endtask

    task automatic end_writes();
        @(posedge reloj);
        rd       <= 1'b1;
        posicion <= '0;
    endtask

    task automatic scan_row(input logic [ROW_W-1:0] row);
        for (int col = 0; col < SCAN_COLS; col++) begin
            @(posedge reloj);
            qh <= COL_W'(col);
            qv <= {row, LINE_W'($urandom)};
        end
    endtask

    task automatic scan_text_rows();
        scan_row(ROW_TIME);
        scan_row(ROW_DATE);
    endtask

    function automatic logic [PAIR_W-1:0] random_bcd_pair();
        return {BCD_W'($urandom % 10), BCD_W'($urandom % 10)};
    endfunction

    function automatic logic [BCD_W-1:0] random_bad_nibble();
        return BCD_W'(10 + $urandom % 6);
    endfunction

    always @(posedge reloj) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, the scans did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h8e6e407c));
        dir_dato = '0;
        posicion = '0;
        rd       = 1'b1;
        qh       = '0;
        qv       = '0;
        while (resetM !== 1'b0) begin
            @(posedge reloj);
        end

        scan_text_rows();                      // Slots are still zero after reset

        for (int s = 1; s <= SLOT_COUNT; s++) begin
            write_slot(SLOT_W'(s), random_bcd_pair(), 1'b0);
        end
        end_writes();
        scan_text_rows();

        // Rows without text
        scan_row(ROW_W'(0));
        scan_row(ROW_TIME - ROW_W'(1));
        scan_row(ROW_TIME + ROW_W'(1));
        scan_row(ROW_W'($urandom % 11));
        scan_row(ROW_W'(63));

        // Bad tens, bad units, and both bad
        write_slot(SLOT_W'(2), {random_bad_nibble(), BCD_W'($urandom % 10)}, 1'b0);
        write_slot(SLOT_W'(5), {BCD_W'($urandom % 10), random_bad_nibble()}, 1'b0);
        write_slot(SLOT_W'(9), {random_bad_nibble(), random_bad_nibble()}, 1'b0);
        end_writes();
        scan_text_rows();

        write_slot(SLOT_W'(3), 8'hEE, 1'b1);
        write_slot(SLOT_W'(0), random_bcd_pair(), 1'b0);
        for (int p = SLOT_COUNT + 1; p < (1 << SLOT_W); p++) begin
            write_slot(SLOT_W'(p), random_bcd_pair(), 1'b0);
        end
        end_writes();
        scan_text_rows();

        repeat (4) @(posedge reloj);           // Let the last positions leave the pipeline
        errors = dut_i.sva_i.fail_count;
        $display("Summary: %0d cycles checked, %0d check failures",
                 dut_i.sva_i.checked_cycles, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic reloj,
    output logic resetM
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        reloj = 1'b0;
        forever #HALF_PERIOD reloj = ~reloj;
    end

    // Reset is synchronous, so it is released on a rising edge
    initial begin
        resetM = 1'b1;
        repeat (RESET_CYCLES) @(posedge reloj);
        resetM <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/clock_display_addr.sv
`default_nettype none

module clock_display_addr (
    input  logic                                               reloj,
    input  logic                                               resetM,
    input  logic [clock_display_pkg::PAIR_W-1:0]               dir_dato,
    input  logic [clock_display_pkg::SLOT_W-1:0]               posicion,
    input  logic                                               rd,
    input  logic [clock_display_pkg::COL_W-1:0]                qh,
    input  logic [clock_display_pkg::ROW_W+clock_display_pkg::LINE_W-1:0] qv,
    output logic [clock_display_pkg::ADDR_W-1:0]               dir_mem
);

    import clock_display_pkg::*;

    field_kind_e       field_kind;
    field_word_u       field_word;
    logic [LINE_W-1:0] glyph_line;
    logic [SLOT_W-1:0] rd_slot;
    logic [PAIR_W-1:0] rd_pair;

    digit_store u_digit_store (
        .reloj    (reloj),
        .resetM   (resetM),
        .dir_dato (dir_dato),
        .posicion (posicion),
        .rd       (rd),
        .rd_slot  (rd_slot),
        .rd_pair  (rd_pair)
    );

    // First stage of the two cycle display path
    screen_field_decode u_screen_field_decode (
        .reloj      (reloj),
        .resetM     (resetM),
        .qh         (qh),
        .qv         (qv),
        .field_kind (field_kind),
        .field_word (field_word),
        .glyph_line (glyph_line)
    );

    glyph_address u_glyph_address (
        .reloj      (reloj),
        .resetM     (resetM),
        .field_kind (field_kind),
        .field_word (field_word),
        .glyph_line (glyph_line),
        .rd_slot    (rd_slot),
        .rd_pair    (rd_pair),
        .dir_mem    (dir_mem)
    );

endmodule

`default_nettype wire

// File: hw/clock_display_pkg.sv
`default_nettype none

package clock_display_pkg;

    localparam int SLOT_COUNT = 9;         // Slots 1 to 9, slot 0 is never stored
    localparam int BCD_W      = 4;
    localparam int PAIR_W     = 8;
    localparam int SLOT_W     = 4;
    localparam int COL_W      = 7;
    localparam int ROW_W      = 6;
    localparam int LINE_W     = 4;
    localparam int CHAR_W     = 8;
    localparam int ADDR_W     = CHAR_W + LINE_W;

    // Character rows that carry text
    localparam logic [ROW_W-1:0] ROW_TIME = 6'd12;
    localparam logic [ROW_W-1:0] ROW_DATE = 6'd15;

    localparam logic [CHAR_W-1:0] ASCII_ZERO = 8'h30;
    localparam logic [CHAR_W-1:0] CENTURY_HI = 8'h32;  // "2"
    localparam logic [CHAR_W-1:0] CENTURY_LO = 8'h30;  // "0"

    // Tens column of each field, every field is four columns wide
    localparam logic [COL_W-1:0] COL_TIME_HOUR  = 7'd8;
    localparam logic [COL_W-1:0] COL_TIME_MIN   = 7'd14;
    localparam logic [COL_W-1:0] COL_TIME_SEC   = 7'd20;
    localparam logic [COL_W-1:0] COL_CRONO_HOUR = 7'd66;
    localparam logic [COL_W-1:0] COL_CRONO_MIN  = 7'd72;
    localparam logic [COL_W-1:0] COL_CRONO_SEC  = 7'd78;
    localparam logic [COL_W-1:0] COL_DAY        = 7'd34;
    localparam logic [COL_W-1:0] COL_MONTH      = 7'd42;
    localparam logic [COL_W-1:0] COL_CENTURY    = 7'd48;
    localparam logic [COL_W-1:0] COL_YEAR       = 7'd52;

    typedef enum logic [1:0] {
        FIELD_BLANK,
        FIELD_DIGIT,
        FIELD_LITERAL
    } field_kind_e;

    // The kind decides which view of the word is valid
    typedef union packed {
        struct packed {
            logic [SLOT_W-1:0] slot;
            logic              tens;   // Set for the tens digit of the pair
            logic [2:0]        spare;
        } digit;
        logic [CHAR_W-1:0] code;
    } field_word_u;

endpackage

`default_nettype wire

// File: hw/digit_store.sv
`default_nettype none

module digit_store (
    input  logic                                reloj,
    input  logic                                resetM,
    input  logic [clock_display_pkg::PAIR_W-1:0] dir_dato,
    input  logic [clock_display_pkg::SLOT_W-1:0] posicion,
    input  logic                                rd,
    input  logic [clock_display_pkg::SLOT_W-1:0] rd_slot,
    output logic [clock_display_pkg::PAIR_W-1:0] rd_pair
);

    import clock_display_pkg::*;

    logic [PAIR_W-1:0] slots [1:SLOT_COUNT];
    logic              wr_en;
    logic              rd_valid;

    // Strobe is active low, out of range slot numbers are ignored
    assign wr_en = !rd && (posicion >= SLOT_W'(1)) && (posicion <= SLOT_W'(SLOT_COUNT));

    always_ff @(posedge reloj) begin
        if (resetM) begin
            for (int i = 1; i <= SLOT_COUNT; i++) begin
                slots[i] <= '0;
            end
        end else if (wr_en) begin
            slots[posicion] <= dir_dato;
        end
    end

    assign rd_valid = (rd_slot >= SLOT_W'(1)) && (rd_slot <= SLOT_W'(SLOT_COUNT));

    always_comb begin
        if (rd_valid) begin
            rd_pair = slots[rd_slot];
        end else begin
            rd_pair = '0;                 // Slot 0 reads as an empty pair
        end
    end

endmodule

`default_nettype wire

// File: hw/glyph_address.sv
`default_nettype none

module glyph_address (
    input  logic                                 reloj,
    input  logic                                 resetM,
    input  clock_display_pkg::field_kind_e       field_kind,
    input  clock_display_pkg::field_word_u       field_word,
    input  logic [clock_display_pkg::LINE_W-1:0] glyph_line,
    output logic [clock_display_pkg::SLOT_W-1:0] rd_slot,
    input  logic [clock_display_pkg::PAIR_W-1:0] rd_pair,
    output logic [clock_display_pkg::ADDR_W-1:0] dir_mem
);

    import clock_display_pkg::*;

    logic [BCD_W-1:0]  nibble;
    logic [CHAR_W-1:0] digit_char;
    logic [CHAR_W-1:0] char_code;
    logic              shown;

    // Only a digit field addresses the store, everything else reads slot 0
    assign rd_slot = (field_kind == FIELD_DIGIT) ? field_word.digit.slot : '0;

    assign nibble = field_word.digit.tens ? rd_pair[PAIR_W-1 -: BCD_W] : rd_pair[BCD_W-1:0];

    always_comb begin
        if (nibble <= BCD_W'(9)) begin
            digit_char = ASCII_ZERO + CHAR_W'(nibble);
        end else begin
            digit_char = '0;              // Not a decimal digit
        end
    end

    always_comb begin
        case (field_kind)
            FIELD_DIGIT: begin
                char_code = digit_char;
                shown     = 1'b1;
            end
            FIELD_LITERAL: begin
                char_code = field_word.code;
                shown     = 1'b1;
            end
            default: begin
                char_code = '0;
                shown     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge reloj) begin
        if (resetM) begin
            dir_mem <= '0;
        end else if (shown) begin
            dir_mem <= {char_code, glyph_line};
        end else begin
            dir_mem <= '0;                // Blank cells address the empty glyph
        end
    end

endmodule

`default_nettype wire

// File: hw/screen_field_decode.sv
`default_nettype none

module screen_field_decode (
    input  logic                                               reloj,
    input  logic                                               resetM,
    input  logic [clock_display_pkg::COL_W-1:0]                qh,
    input  logic [clock_display_pkg::ROW_W+clock_display_pkg::LINE_W-1:0] qv,
    output clock_display_pkg::field_kind_e                     field_kind,
    output clock_display_pkg::field_word_u                     field_word,
    output logic [clock_display_pkg::LINE_W-1:0]               glyph_line
);

    import clock_display_pkg::*;

    logic [COL_W-1:0]  col_q;
    logic [ROW_W-1:0]  row_q;
    logic [LINE_W-1:0] line_q;

    logic [SLOT_W-1:0] hit_slot;
    logic [COL_W-1:0]  hit_col;

    function automatic logic covers(input logic [COL_W-1:0] col,
                                    input logic [COL_W-1:0] start);
        return (col >= start) && (col < start + COL_W'(4));
    endfunction

    // Row 0 decodes as blank, so the reset position shows nothing
    always_ff @(posedge reloj) begin
        if (resetM) begin
            col_q  <= '0;
            row_q  <= '0;
            line_q <= '0;
        end else begin
            col_q  <= qh;
            row_q  <= qv[LINE_W +: ROW_W];
            line_q <= qv[LINE_W-1:0];
        end
    end

    // Pick the digit field under the column, slot 0 means none
    always_comb begin
        hit_slot = '0;
        hit_col  = '0;
        if (row_q == ROW_TIME) begin
            if (covers(col_q, COL_TIME_HOUR)) begin
                hit_slot = SLOT_W'(1);
                hit_col  = COL_TIME_HOUR;
            end else if (covers(col_q, COL_TIME_MIN)) begin
                hit_slot = SLOT_W'(2);
                hit_col  = COL_TIME_MIN;
            end else if (covers(col_q, COL_TIME_SEC)) begin
                hit_slot = SLOT_W'(3);
                hit_col  = COL_TIME_SEC;
            end else if (covers(col_q, COL_CRONO_HOUR)) begin
                hit_slot = SLOT_W'(4);
                hit_col  = COL_CRONO_HOUR;
            end else if (covers(col_q, COL_CRONO_MIN)) begin
                hit_slot = SLOT_W'(5);
                hit_col  = COL_CRONO_MIN;
            end else if (covers(col_q, COL_CRONO_SEC)) begin
                hit_slot = SLOT_W'(6);
                hit_col  = COL_CRONO_SEC;
            end
        end else if (row_q == ROW_DATE) begin
            if (covers(col_q, COL_DAY)) begin
                hit_slot = SLOT_W'(7);
                hit_col  = COL_DAY;
            end else if (covers(col_q, COL_MONTH)) begin
                hit_slot = SLOT_W'(8);
                hit_col  = COL_MONTH;
            end else if (covers(col_q, COL_YEAR)) begin
                hit_slot = SLOT_W'(9);
                hit_col  = COL_YEAR;
            end
        end
    end

    always_comb begin
        field_kind = FIELD_BLANK;
        field_word = '0;
        if (hit_slot != '0) begin
            field_kind             = FIELD_DIGIT;
            field_word.digit.slot  = hit_slot;
            field_word.digit.tens  = col_q < hit_col + COL_W'(2);
            field_word.digit.spare = '0;
        end else if (row_q == ROW_DATE && covers(col_q, COL_CENTURY)) begin
            field_kind = FIELD_LITERAL;
            // First half of the field is the "2", second half the "0"
            if (col_q < COL_CENTURY + COL_W'(2)) begin
                field_word.code = CENTURY_HI;
            end else begin
                field_word.code = CENTURY_LO;
            end
        end
    end

    assign glyph_line = line_q;

endmodule

`default_nettype wire

// File: list.f
hw/clock_display_pkg.sv
hw/digit_store.sv
hw/screen_field_decode.sv
hw/glyph_address.sv
hw/clock_display_addr.sv
bench/tb_clock_gen.sv
bench/clock_display_sva.sv
bench/tb_clock_display.sv
